// File: verilog/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Unified instruction and data RAM, in 32-bit words
`define CORE_MEM_WORDS 1024

// First fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// ABI register a0, shown on the top-level status port
`define CORE_REG_A0 5'd10

`endif

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_M, FWD_W} fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    // Decode to execute
    typedef struct packed {
        logic        valid;
        word_t       pc;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        word_t       rs1_data;
        word_t       rs2_data;
        word_t       imm;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        result_src_e result_src;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        halt;
    } exec_pkt_t;

    // Execute to memory, reused for the W register
    typedef struct packed {
        logic        valid;
        word_t       pc;
        reg_idx_t    rd;
        word_t       alu_result;
        word_t       store_data;
        result_src_e result_src;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        halt;
    } mem_pkt_t;

    typedef struct packed {
        logic     valid;   // Register write enable
        reg_idx_t rd;
        word_t    data;
    } wb_pkt_t;

    typedef struct packed {
        word_t addr;
        logic  we;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  redirect,
    input  core_pkg::word_t       redirect_pc,
    input  logic                  fetch_grant,
    input  core_pkg::word_t       rdata,
    output logic                  fetch_req,
    output core_pkg::mem_req_t    fetch_addr,
    output core_pkg::fetch_pkt_t  fetch_pkt
);

    core_pkg::word_t      pc;
    core_pkg::word_t      inflight_pc;
    logic                 inflight;      // Read granted last cycle so its word is on rdata now
    core_pkg::fetch_pkt_t held;          // Word parked while decode is stalled

    assign fetch_req = !reset && !stall;

    // A redirect goes straight to the RAM so the target costs only one bubble
    assign fetch_addr = '{addr: redirect ? redirect_pc : pc, we: 1'b0, wdata: '0};

    assign fetch_pkt = held.valid ? held
                     : core_pkg::fetch_pkt_t'{valid: inflight, pc: inflight_pc, instr: rdata};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `CORE_RESET_PC;
            inflight   <= 1'b0;
            held.valid <= 1'b0;
        end else begin
            inflight <= fetch_grant;
            if (fetch_grant) begin
                pc <= fetch_addr.addr + 32'd4;
            end else if (redirect) begin
                pc <= redirect_pc;   // Lost arbitration so retry the target next cycle
            end
            if (!stall) begin
                held.valid <= 1'b0;  // Decode takes it this cycle
            end else if (!held.valid) begin
                held.valid <= inflight;
            end
        end
        inflight_pc <= fetch_addr.addr;
        if (!held.valid) begin
            held.pc    <= inflight_pc;
            held.instr <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  core_pkg::fetch_pkt_t  fetch_pkt,
    input  core_pkg::word_t       rs1_data,
    input  core_pkg::word_t       rs2_data,
    input  core_pkg::word_t       fwd_m_result,
    input  logic                  cmp_fwd1,
    input  logic                  cmp_fwd2,
    output core_pkg::reg_idx_t    rs1,
    output core_pkg::reg_idx_t    rs2,
    output logic                  is_branch,
    output logic                  redirect,
    output core_pkg::word_t       redirect_pc,
    output core_pkg::exec_pkt_t   exec_pkt
);

    core_pkg::fetch_pkt_t d_pkt;
    core_pkg::opcode_e    opcode;
    core_pkg::word_t      instr;
    core_pkg::word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    core_pkg::word_t      cmp_a, cmp_b;
    logic                 is_jal;
    logic                 taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            d_pkt.valid <= 1'b0;
        end else if (!stall) begin
            d_pkt       <= fetch_pkt;
            d_pkt.valid <= fetch_pkt.valid && !flush;  // Wrong-path word behind a redirect
        end
    end

    assign instr  = d_pkt.instr;
    assign opcode = core_pkg::opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        exec_pkt          = '0;
        exec_pkt.valid    = d_pkt.valid;
        exec_pkt.pc       = d_pkt.pc;
        exec_pkt.rs1      = rs1;
        exec_pkt.rs2      = rs2;
        exec_pkt.rd       = instr[11:7];
        exec_pkt.rs1_data = rs1_data;
        exec_pkt.rs2_data = rs2_data;
        is_branch         = 1'b0;
        is_jal            = 1'b0;
        case (opcode)
            core_pkg::OPC_OP: begin
                exec_pkt.reg_write = 1'b1;
                case ({instr[30], instr[14:12]})
                    4'b1_000: exec_pkt.alu_op = core_pkg::ALU_SUB;
                    4'b0_111: exec_pkt.alu_op = core_pkg::ALU_AND;
                    4'b0_110: exec_pkt.alu_op = core_pkg::ALU_OR;
                    4'b0_100: exec_pkt.alu_op = core_pkg::ALU_XOR;
                    4'b0_010: exec_pkt.alu_op = core_pkg::ALU_SLT;
                    default:  exec_pkt.alu_op = core_pkg::ALU_ADD;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin   // ADDI only
                exec_pkt.reg_write   = 1'b1;
                exec_pkt.alu_src_imm = 1'b1;
                exec_pkt.imm         = imm_i;
            end
            core_pkg::OPC_LUI: begin
                exec_pkt.reg_write   = 1'b1;
                exec_pkt.alu_src_imm = 1'b1;
                exec_pkt.alu_op      = core_pkg::ALU_PASS_B;
                exec_pkt.imm         = imm_u;
            end
            core_pkg::OPC_LOAD: begin
                exec_pkt.reg_write   = 1'b1;
                exec_pkt.mem_read    = 1'b1;
                exec_pkt.alu_src_imm = 1'b1;
                exec_pkt.result_src  = core_pkg::RES_MEM;
                exec_pkt.imm         = imm_i;
            end
            core_pkg::OPC_STORE: begin
                exec_pkt.mem_write   = 1'b1;
                exec_pkt.alu_src_imm = 1'b1;
                exec_pkt.imm         = imm_s;
            end
            core_pkg::OPC_BRANCH: begin
                is_branch    = d_pkt.valid;
                exec_pkt.imm = imm_b;
            end
            core_pkg::OPC_JAL: begin
                is_jal              = d_pkt.valid;
                exec_pkt.reg_write  = 1'b1;
                exec_pkt.result_src = core_pkg::RES_PC4;
                exec_pkt.imm        = imm_j;
            end
            core_pkg::OPC_SYSTEM: exec_pkt.halt = d_pkt.valid;  // Only a live ECALL halts
            default: ;
        endcase
    end

    // Branch compare, M result forwarded in
    assign cmp_a = cmp_fwd1 ? fwd_m_result : rs1_data;
    assign cmp_b = cmp_fwd2 ? fwd_m_result : rs2_data;
    assign taken = instr[12] ? (cmp_a != cmp_b) : (cmp_a == cmp_b);  // BNE : BEQ

    assign redirect    = !stall && (is_jal || (is_branch && taken));
    assign redirect_pc = d_pkt.pc + exec_pkt.imm;

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file (
    input  logic                clk,
    input  core_pkg::reg_idx_t  rs1,
    input  core_pkg::reg_idx_t  rs2,
    input  core_pkg::wb_pkt_t   wb,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    output core_pkg::word_t     rega0
);

    core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 hardwired, W result bypassed into the same-cycle read
    assign rs1_data = (rs1 == 5'd0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

    assign rega0 = regs[`CORE_REG_A0];

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  core_pkg::reg_idx_t  d_rs1,
    input  core_pkg::reg_idx_t  d_rs2,
    input  logic                d_is_branch,
    input  logic                d_is_ecall,
    input  core_pkg::exec_pkt_t e_pkt,
    input  core_pkg::mem_pkt_t  m_pkt,
    input  core_pkg::wb_pkt_t   wb,
    output logic                stall,
    output logic                flush_e,
    output logic                cmp_fwd1,
    output logic                cmp_fwd2,
    output core_pkg::fwd_sel_e  alu_fwd1,
    output core_pkg::fwd_sel_e  alu_fwd2
);

    logic load_use;
    logic branch_wait;

    // Producer writes a live, nonzero rd that the consumer reads
    function automatic logic hit(input logic writes, input core_pkg::reg_idx_t rd,
                                 input core_pkg::reg_idx_t rs);
        return writes && rd != 5'd0 && rd == rs;
    endfunction

    assign load_use = hit(e_pkt.valid && e_pkt.mem_read, e_pkt.rd, d_rs1)
                   || hit(e_pkt.valid && e_pkt.mem_read, e_pkt.rd, d_rs2);

    // Compare in D only sees M ALU results, so wait on E and on loads in M
    assign branch_wait = d_is_branch
        && (hit(e_pkt.valid && e_pkt.reg_write, e_pkt.rd, d_rs1)
         || hit(e_pkt.valid && e_pkt.reg_write, e_pkt.rd, d_rs2)
         || hit(m_pkt.valid && m_pkt.mem_read, m_pkt.rd, d_rs1)
         || hit(m_pkt.valid && m_pkt.mem_read, m_pkt.rd, d_rs2));

    // ECALL freezes fetch and D but keeps feeding E so it can retire
    assign stall   = load_use || branch_wait || d_is_ecall;
    assign flush_e = load_use || branch_wait;

    assign cmp_fwd1 = hit(m_pkt.valid && m_pkt.reg_write, m_pkt.rd, d_rs1);
    assign cmp_fwd2 = hit(m_pkt.valid && m_pkt.reg_write, m_pkt.rd, d_rs2);

    assign alu_fwd1 = hit(m_pkt.valid && m_pkt.reg_write, m_pkt.rd, e_pkt.rs1) ? core_pkg::FWD_M
                    : hit(wb.valid, wb.rd, e_pkt.rs1) ? core_pkg::FWD_W : core_pkg::FWD_NONE;
    assign alu_fwd2 = hit(m_pkt.valid && m_pkt.reg_write, m_pkt.rd, e_pkt.rs2) ? core_pkg::FWD_M
                    : hit(wb.valid, wb.rd, e_pkt.rs2) ? core_pkg::FWD_W : core_pkg::FWD_NONE;

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  core_pkg::exec_pkt_t  exec_pkt,
    input  core_pkg::fwd_sel_e   alu_fwd1,
    input  core_pkg::fwd_sel_e   alu_fwd2,
    input  core_pkg::word_t      m_result,
    input  core_pkg::wb_pkt_t    wb,
    output core_pkg::exec_pkt_t  e_pkt,
    output core_pkg::mem_pkt_t   mem_pkt
);

    core_pkg::word_t op_a, op_b_reg, op_b, alu_out;

    function automatic core_pkg::word_t fwd_mux(input core_pkg::fwd_sel_e sel,
                                                input core_pkg::word_t reg_val,
                                                input core_pkg::word_t m_val,
                                                input core_pkg::word_t w_val);
        case (sel)
            core_pkg::FWD_M: return m_val;
            core_pkg::FWD_W: return w_val;
            default:         return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        e_pkt <= exec_pkt;
        if (reset || flush) begin
            e_pkt.valid <= 1'b0;   // Bubble
        end
    end

    assign op_a     = fwd_mux(alu_fwd1, e_pkt.rs1_data, m_result, wb.data);
    assign op_b_reg = fwd_mux(alu_fwd2, e_pkt.rs2_data, m_result, wb.data);
    assign op_b     = e_pkt.alu_src_imm ? e_pkt.imm : op_b_reg;

    always_comb begin
        case (e_pkt.alu_op)
            core_pkg::ALU_SUB:    alu_out = op_a - op_b;
            core_pkg::ALU_AND:    alu_out = op_a & op_b;
            core_pkg::ALU_OR:     alu_out = op_a | op_b;
            core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            core_pkg::ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_PASS_B: alu_out = op_b;
            default:              alu_out = op_a + op_b;
        endcase
    end

    // JAL link goes out as the result so M forwarding sees pc+4
    assign mem_pkt = '{
        valid:      e_pkt.valid,
        pc:         e_pkt.pc,
        rd:         e_pkt.rd,
        alu_result: (e_pkt.result_src == core_pkg::RES_PC4) ? e_pkt.pc + 32'd4 : alu_out,
        store_data: op_b_reg,
        result_src: e_pkt.result_src,
        reg_write:  e_pkt.reg_write,
        mem_read:   e_pkt.mem_read,
        mem_write:  e_pkt.mem_write,
        halt:       e_pkt.halt
    };

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::mem_pkt_t  mem_pkt,
    input  core_pkg::word_t     rdata,
    output logic                data_req,
    output core_pkg::mem_req_t  data_addr,
    output core_pkg::mem_pkt_t  m_pkt,
    output core_pkg::wb_pkt_t   wb,
    output logic                halted
);

    core_pkg::mem_pkt_t w_pkt;

    always_ff @(posedge clk) begin
        m_pkt <= mem_pkt;
        w_pkt <= m_pkt;
        if (reset) begin
            m_pkt.valid <= 1'b0;
            w_pkt.valid <= 1'b0;
            halted      <= 1'b0;
        end else if (m_pkt.valid && m_pkt.halt) begin
            halted <= 1'b1;    // Sticky, set as ECALL enters W
        end
    end

    assign data_req  = m_pkt.valid && (m_pkt.mem_read || m_pkt.mem_write);
    assign data_addr = '{addr: m_pkt.alu_result, we: m_pkt.mem_write, wdata: m_pkt.store_data};

    // Load data arrives on rdata one cycle after the M request
    always_comb begin
        wb.valid = w_pkt.valid && w_pkt.reg_write;
        wb.rd    = w_pkt.rd;
        case (w_pkt.result_src)
            core_pkg::RES_MEM: wb.data = rdata;
            core_pkg::RES_PC4: wb.data = w_pkt.pc + 32'd4;
            default:           wb.data = w_pkt.alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/shared_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module shared_memory (
    input  logic                clk,
    input  logic                fetch_req,
    input  core_pkg::mem_req_t  fetch_addr,
    input  logic                data_req,
    input  core_pkg::mem_req_t  data_addr,
    output logic                fetch_grant,
    output core_pkg::word_t     rdata
);

    localparam int ADDR_BITS = $clog2(`CORE_MEM_WORDS);

    core_pkg::word_t       mem [`CORE_MEM_WORDS];
    core_pkg::mem_req_t    req;
    logic [ADDR_BITS-1:0]  idx;

    //////////////////////////////////////////////////////////////////////
    // Arbiter, data port always wins
    //////////////////////////////////////////////////////////////////////

    assign fetch_grant = fetch_req && !data_req;
    assign req         = data_req ? data_addr : fetch_addr;
    assign idx         = req.addr[ADDR_BITS+1:2];   // Word addressed

    //////////////////////////////////////////////////////////////////////
    // Single-port RAM, one cycle read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (data_req && data_addr.we) begin
            mem[idx] <= req.wdata;
        end
        rdata <= mem[idx];   // Read before write on a store
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic             clk,
    input  logic             reset,
    output core_pkg::word_t  rega0,
    output logic             halted
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    logic                 fetch_req, fetch_grant, data_req;
    core_pkg::mem_req_t   fetch_addr, data_addr;
    core_pkg::word_t      rdata;
    core_pkg::fetch_pkt_t fetch_pkt;

    logic                 stall, flush_e, redirect, d_is_branch;
    logic                 cmp_fwd1, cmp_fwd2;
    core_pkg::fwd_sel_e   alu_fwd1, alu_fwd2;
    core_pkg::word_t      redirect_pc, rs1_data, rs2_data;
    core_pkg::reg_idx_t   rs1, rs2;

    core_pkg::exec_pkt_t  d_exec, e_pkt;
    core_pkg::mem_pkt_t   mem_pkt, m_pkt;
    core_pkg::wb_pkt_t    wb;

    //////////////////////////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////////////////////////

    fetch_stage fetch_stage_i (
        .clk, .reset, .stall, .redirect, .redirect_pc, .fetch_grant, .rdata,
        .fetch_req, .fetch_addr, .fetch_pkt
    );

    decode_stage decode_stage_i (
        .clk, .reset, .stall,
        .flush        (redirect),
        .fetch_pkt, .rs1_data, .rs2_data,
        .fwd_m_result (m_pkt.alu_result),
        .cmp_fwd1, .cmp_fwd2, .rs1, .rs2,
        .is_branch    (d_is_branch),
        .redirect, .redirect_pc,
        .exec_pkt     (d_exec)
    );

    register_file register_file_i (
        .clk, .rs1, .rs2, .wb, .rs1_data, .rs2_data, .rega0
    );

    hazard_unit hazard_unit_i (
        .d_rs1       (rs1),
        .d_rs2       (rs2),
        .d_is_branch,
        .d_is_ecall  (d_exec.halt),   // Valid-qualified in decode
        .e_pkt, .m_pkt, .wb, .stall, .flush_e,
        .cmp_fwd1, .cmp_fwd2, .alu_fwd1, .alu_fwd2
    );

    execute_stage execute_stage_i (
        .clk, .reset,
        .flush    (flush_e),
        .exec_pkt (d_exec),
        .alu_fwd1, .alu_fwd2,
        .m_result (m_pkt.alu_result),
        .wb, .e_pkt, .mem_pkt
    );

    memory_stage memory_stage_i (
        .clk, .reset, .mem_pkt, .rdata, .data_req, .data_addr, .m_pkt, .wb, .halted
    );

    shared_memory shared_memory_i (
        .clk, .fetch_req, .fetch_addr, .data_req, .data_addr, .fetch_grant, .rdata
    );

endmodule

`default_nettype wire

// File: tb/core_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_chk (
    input logic               clk,
    input logic               reset,
    input logic               fetch_grant,
    input logic               data_req,
    input core_pkg::mem_req_t data_addr,
    input core_pkg::word_t    rdata,
    input core_pkg::word_t    mem [`CORE_MEM_WORDS],   // RAM contents
    input logic               halted
);

    localparam int ADDR_BITS = $clog2(`CORE_MEM_WORDS);

    int unsigned fail_count = 0;

    // Data port has strict priority over fetch
    fetch_yields: assert property (@(posedge clk) disable iff (reset)
        data_req |-> !fetch_grant)
        else begin
            fail_count++;
            $error("fetch granted while the data port requests");
        end

    // A store lands in the RAM and a load returns the addressed word one cycle later
    data_served: assert property (@(posedge clk) disable iff (reset)
        data_req |=> ($past(data_addr.we)
            ? mem[$past(data_addr.addr[ADDR_BITS+1:2])] == $past(data_addr.wdata)
            : rdata == mem[$past(data_addr.addr[ADDR_BITS+1:2])]))
        else begin
            fail_count++;
            $error("data request not carried out by the RAM");
        end

    // Sticky until a synchronous reset
    halt_sticky: assert property (@(posedge clk)
        $fell(halted) |-> $past(reset))
        else begin
            fail_count++;
            $error("halted dropped without reset");
        end

endmodule

// Arbiter nets and the status port both live at the top
bind core_top core_chk core_chk_i (
    .clk,
    .reset,
    .fetch_grant,
    .data_req,
    .data_addr,
    .rdata,
    .mem         (shared_memory_i.mem),
    .halted
);

`default_nettype wire

// File: tb/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_tb;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;

    localparam core_pkg::reg_idx_t A0        = `CORE_REG_A0;
    localparam core_pkg::word_t    DATA_BASE = 32'h0000_0400;   // Byte address of data area
    localparam core_pkg::word_t    ECALL     = 32'h0000_0073;

    logic            clk;
    logic            reset;
    core_pkg::word_t rega0;
    logic            halted;

    core_pkg::word_t prog [$];    // Program image, word 0 at the reset PC
    integer          seed;
    int              cycles = 0;

    core_top core_top_i (.clk, .reset, .rega0, .halted);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, the core did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and checks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h",
                                name, got, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                                name, got, expected));
        end
    endtask

    task automatic check_assertions();
        if (core_top_i.core_chk_i.fail_count != 0) begin
            abort_run("a bound assertion on the arbiter or the halt flag failed");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic core_pkg::word_t enc_r(input logic [6:0] funct7,
                                              input logic [2:0] funct3,
                                              input core_pkg::reg_idx_t rd, rs1, rs2);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic core_pkg::word_t enc_i(input core_pkg::opcode_e opcode,
                                              input logic [2:0] funct3,
                                              input core_pkg::reg_idx_t rd, rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // SW only
    function automatic core_pkg::word_t enc_s(input core_pkg::reg_idx_t rs2, rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OPC_STORE};
    endfunction

    function automatic core_pkg::word_t enc_b(input logic [2:0] funct3,
                                              input core_pkg::reg_idx_t rs1, rs2,
                                              input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11],
                core_pkg::OPC_BRANCH};
    endfunction

    function automatic core_pkg::word_t enc_u(input core_pkg::reg_idx_t rd,
                                              input logic [19:0] imm);
        return {imm, rd, core_pkg::OPC_LUI};
    endfunction

    function automatic core_pkg::word_t enc_j(input core_pkg::reg_idx_t rd,
                                              input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::OPC_JAL};
    endfunction

    task automatic emit(input core_pkg::word_t instr);
        prog.push_back(instr);
    endtask

    // LUI then ADDI, upper half rounded for the sign-extended low half
    task automatic emit_li(input core_pkg::reg_idx_t rd, input core_pkg::word_t value);
        core_pkg::word_t upper;
        upper = value + 32'h800;
        emit(enc_u(rd, upper[31:12]));
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, rd, rd, value[11:0]));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program control
    //////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic start_program();
        reset = 1'b1;
        repeat (5) step();
        check_bit("halted", halted, 1'b0);
        for (int i = 0; i < `CORE_MEM_WORDS; i++) begin
            core_top_i.shared_memory_i.mem[i] = {i[11:0], 20'h00013};  // ADDI x0, x0, i
        end
        foreach (prog[k]) begin
            core_top_i.shared_memory_i.mem[k] = prog[k];
        end
        reset = 1'b0;
        step();
        check_bit("halted", halted, 1'b0);   // Just out of reset
    endtask

    task automatic wait_halted();
        while (halted !== 1'b1) begin
            step();
        end
        check_assertions();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        prog.delete();
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, A0, 5'd0, 12'd0));
        emit(ECALL);
        start_program();
        repeat (3) begin
            check_bit("halted", halted, 1'b0);
            step();
        end
        wait_halted();
        check_word("rega0", rega0, 32'd0);
    endtask

    task automatic test_alu_forwarding();
        core_pkg::word_t a, b, t7, t8, t9, t28, t29, t30;
        a = $random(seed);
        b = $random(seed);
        prog.delete();
        emit_li(5'd5, a);
        emit_li(5'd6, b);
        emit(enc_r(7'h00, 3'b000, 5'd7, 5'd5, 5'd6));     // add
        emit(enc_r(7'h20, 3'b000, 5'd8, 5'd7, 5'd5));     // sub
        emit(enc_r(7'h00, 3'b111, 5'd9, 5'd8, 5'd6));     // and
        emit(enc_r(7'h00, 3'b110, 5'd28, 5'd9, 5'd7));    // or
        emit(enc_r(7'h00, 3'b100, 5'd29, 5'd28, 5'd8));   // xor
        emit(enc_r(7'h00, 3'b010, 5'd30, 5'd29, 5'd7));   // slt
        emit(enc_r(7'h00, 3'b000, A0, 5'd29, 5'd30));
        emit(ECALL);
        t7  = a + b;
        t8  = t7 - a;
        t9  = t8 & b;
        t28 = t9 | t7;
        t29 = t28 ^ t8;
        t30 = ($signed(t29) < $signed(t7)) ? 32'd1 : 32'd0;
        start_program();
        wait_halted();
        check_word("rega0", rega0, t29 + t30);
    endtask

    task automatic test_load_store();
        core_pkg::word_t value;
        logic [11:0]     imm;
        value = $random(seed);
        imm   = 12'($random(seed));
        prog.delete();
        emit_li(5'd5, value);
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 5'd6, 5'd0, DATA_BASE[11:0]));
        emit(enc_s(5'd5, 5'd6, 12'd0));
        emit(enc_i(core_pkg::OPC_LOAD, 3'b010, 5'd7, 5'd6, 12'd0));
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, A0, 5'd7, imm));   // Uses the load at once
        emit(ECALL);
        start_program();
        wait_halted();
        check_word("rega0", rega0, value + {{20{imm[11]}}, imm});
        check_word("mem", core_top_i.shared_memory_i.mem[DATA_BASE[11:2]], value);
    endtask

    task automatic test_branch_jal();
        int              n;
        core_pkg::word_t expected;
        n = 5 + ($random(seed) & 15);
        prog.delete();
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, A0, 5'd0, 12'd0));       // 0x00
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 5'd5, 5'd0, 12'(n)));    // 0x04
        emit(enc_r(7'h00, 3'b000, A0, A0, 5'd5));                         // 0x08 loop body
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 5'd5, 5'd5, 12'hfff));   // 0x0c
        emit(enc_b(3'b001, 5'd5, 5'd0, 13'h1ff8));                        // 0x10 bne to 0x08
        emit(enc_b(3'b000, A0, 5'd0, 13'd8));                             // 0x14 beq not taken
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, A0, A0, 12'd1));         // 0x18
        emit(enc_j(5'd1, 21'd8));                                         // 0x1c jal to 0x24
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, A0, A0, 12'h7ff));       // 0x20 jumped over
        emit(enc_r(7'h00, 3'b000, A0, A0, 5'd1));                         // 0x24 add link
        emit(ECALL);
        expected = (n * (n + 1)) / 2 + 1 + (32'h1c + 32'd4);
        start_program();
        wait_halted();
        check_word("rega0", rega0, expected);
    endtask

    task automatic test_arbitration();
        core_pkg::word_t vals [10];
        core_pkg::word_t expected;
        expected = 32'd0;
        prog.delete();
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, A0, 5'd0, 12'd0));
        emit(enc_i(core_pkg::OPC_OP_IMM, 3'b000, 5'd6, 5'd0, DATA_BASE[11:0]));
        for (int k = 0; k < 10; k++) begin
            vals[k]  = $random(seed);
            expected = expected + vals[k];
            emit_li(5'd5, vals[k]);
            emit(enc_s(5'd5, 5'd6, 12'(4 * k)));
            emit(enc_i(core_pkg::OPC_LOAD, 3'b010, 5'd7, 5'd6, 12'(4 * k)));
            emit(enc_r(7'h00, 3'b000, A0, A0, 5'd7));
        end
        emit(ECALL);
        start_program();
        while (!(core_top_i.m_pkt.valid && core_top_i.m_pkt.halt)) begin
            step();
        end
        check_bit("halted", halted, 1'b0);   // ECALL in M, not retired yet
        step();
        check_bit("halted", halted, 1'b1);
        check_assertions();
        check_word("rega0", rega0, expected);
        for (int k = 0; k < 10; k++) begin
            check_word("mem", core_top_i.shared_memory_i.mem[DATA_BASE[11:2] + k], vals[k]);
        end
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        seed  = 52;
        test_reset_state();
        test_alu_forwarding();
        test_load_store();
        test_branch_jal();
        test_arbitration();
        if (core_top_i.core_chk_i.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("a bound assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/shared_memory.sv
verilog/core_top.sv
tb/core_chk.sv
tb/core_tb.sv
